/* include/rv_core_params.svh */
// Width, register count and reset PC macros for the RV64 multicycle core.
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

//--------------------------------------------------------------------------
// Datapath widths.
//--------------------------------------------------------------------------

// One data word, also the PC and immediate width.
`define RV_XLEN 64
`define RV_ILEN 32
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// RV64 shifts take six bits of shift amount.
`define RV_SHAMT_W 6

//--------------------------------------------------------------------------
// Program counter.
//--------------------------------------------------------------------------
`define RV_RESET_PC 64'h0000_0000_8000_0000
`define RV_INSTR_BYTES 4

`endif

/* verilog/rv_core_pkg.sv */
// Vector types and enums for opcodes, ALU ops, operand selects, branches, FSM states.
`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]       xlen_t;
    typedef logic [`RV_ILEN-1:0]       instr_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes that the core executes.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} op_a_sel_t;

    typedef enum logic {B_RS2, B_IMM} op_b_sel_t;

    // BR_JUMP is the unconditional JAL case.
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } branch_cond_t;

    typedef enum logic [1:0] {
        S_IDLE, S_DECODE, S_EXECUTE, S_RETIRE
    } seq_state_t;

endpackage

`default_nettype wire

/* verilog/rv_decode.sv */
// Instruction register, sequencer FSM, field extraction, immediates and control decode.
`default_nettype none

`include "rv_core_params.svh"

module rv_decode
    import rv_core_pkg::*;
(
    input  logic         clk,
    input  logic         i_reset,
    input  logic         i_instr_valid,
    input  instr_t       i_instr,
    output logic         o_ready,
    output reg_addr_t    o_rs1,
    output reg_addr_t    o_rs2,
    output reg_addr_t    o_rd,
    output xlen_t        o_imm,
    output alu_op_t      o_alu_op,
    output op_a_sel_t    o_op_a_sel,
    output op_b_sel_t    o_op_b_sel,
    output branch_cond_t o_branch_cond,
    output logic         o_writes_rd,
    output logic         o_illegal,
    output logic         o_operand_en,
    output logic         o_alu_en,
    output logic         o_retire
);

    seq_state_t s_state;
    seq_state_t s_next_state;
    instr_t     s_instr;
    opcode_t    s_opcode;
    logic [2:0] s_funct3;
    logic [6:0] s_funct7;
    logic       s_writes;
    xlen_t      s_imm_i;
    xlen_t      s_imm_u;
    xlen_t      s_imm_b;
    xlen_t      s_imm_j;

    // Same funct3 map for OP and OP-IMM, alt picks SUB or SRA.
    function automatic alu_op_t alu_from_funct3(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    //--------------------------------------------------------------------------
    // Sequencer. One instruction in flight, four states per instruction.
    //--------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            s_state <= S_IDLE;
        end else begin
            s_state <= s_next_state;
        end
    end

    always_comb begin
        case (s_state)
            S_IDLE:    s_next_state = i_instr_valid ? S_DECODE : S_IDLE;
            S_DECODE:  s_next_state = S_EXECUTE;
            S_EXECUTE: s_next_state = S_RETIRE;
            default:   s_next_state = S_IDLE;
        endcase
    end

    assign o_ready      = (s_state == S_IDLE);
    assign o_operand_en = (s_state == S_DECODE);
    assign o_alu_en     = (s_state == S_EXECUTE);
    assign o_retire     = (s_state == S_RETIRE);

    // Instruction register, loaded on acceptance only.
    always_ff @(posedge clk) begin
        if (o_ready && i_instr_valid) begin
            s_instr <= i_instr;
        end
    end

    //--------------------------------------------------------------------------
    // Fields and immediates.
    //--------------------------------------------------------------------------
    assign s_opcode = opcode_t'(s_instr[6:0]);
    assign o_rd     = s_instr[11:7];
    assign s_funct3 = s_instr[14:12];
    assign o_rs1    = s_instr[19:15];
    assign o_rs2    = s_instr[24:20];
    assign s_funct7 = s_instr[31:25];

    assign s_imm_i = {{(`RV_XLEN-12){s_instr[31]}}, s_instr[31:20]};
    assign s_imm_u = {{(`RV_XLEN-32){s_instr[31]}}, s_instr[31:12], 12'b0};
    assign s_imm_b = {{(`RV_XLEN-13){s_instr[31]}}, s_instr[31], s_instr[7],
                      s_instr[30:25], s_instr[11:8], 1'b0};
    assign s_imm_j = {{(`RV_XLEN-21){s_instr[31]}}, s_instr[31], s_instr[19:12],
                      s_instr[20], s_instr[30:21], 1'b0};

    // Control decode.
    always_comb begin
        o_alu_op      = ALU_ADD;
        o_op_a_sel    = A_RS1;
        o_op_b_sel    = B_RS2;
        o_branch_cond = BR_NONE;
        o_imm         = '0;
        o_illegal     = 1'b0;
        s_writes      = 1'b0;
        case (s_opcode)
            OPC_OP: begin
                o_alu_op = alu_from_funct3(s_funct3, s_funct7[5]);
                s_writes = 1'b1;
            end
            OPC_OP_IMM: begin
                // No SUB here. Only the right shift looks at funct7.
                o_alu_op   = alu_from_funct3(s_funct3, (s_funct3 == 3'b101) && s_funct7[5]);
                o_op_b_sel = B_IMM;
                o_imm      = s_imm_i;
                s_writes   = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                o_op_a_sel = (s_opcode == OPC_LUI) ? A_ZERO : A_PC;
                o_op_b_sel = B_IMM;
                o_imm      = s_imm_u;
                s_writes   = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm = s_imm_b;
                case (s_funct3)
                    3'b000:  o_branch_cond = BR_EQ;
                    3'b001:  o_branch_cond = BR_NE;
                    3'b100:  o_branch_cond = BR_LT;
                    3'b101:  o_branch_cond = BR_GE;
                    3'b110:  o_branch_cond = BR_LTU;
                    3'b111:  o_branch_cond = BR_GEU;
                    default: o_illegal     = 1'b1;
                endcase
            end
            OPC_JAL: begin
                o_imm         = s_imm_j;
                o_branch_cond = BR_JUMP;
                s_writes      = 1'b1;
            end
            default: o_illegal = 1'b1;
        endcase
    end

    assign o_writes_rd = s_writes && (o_rd != '0);

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
// 32-entry integer register file, two async read ports, one sync write port.
`default_nettype none

`include "rv_core_params.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  reg_addr_t i_rd,
    input  logic      i_we,
    input  xlen_t     i_wdata,
    output xlen_t     o_rs1_data,
    output xlen_t     o_rs2_data
);

    xlen_t s_regs [`RV_NUM_REGS];

    // Architectural state, so every register starts at zero.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            s_regs[i_rd] <= i_wdata;
        end
    end

    // x0 reads as zero.
    assign o_rs1_data = (i_rs1 == '0) ? '0 : s_regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : s_regs[i_rs2];

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
// Operand registers, operand selects, ALU, registered result and compare flags.
`default_nettype none

`include "rv_core_params.svh"

module rv_execute
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_operand_en,
    input  logic      i_alu_en,
    input  xlen_t     i_rs1_data,
    input  xlen_t     i_rs2_data,
    input  xlen_t     i_imm,
    input  xlen_t     i_pc,
    input  alu_op_t   i_alu_op,
    input  op_a_sel_t i_op_a_sel,
    input  op_b_sel_t i_op_b_sel,
    output xlen_t     o_result,
    output logic      o_eq,
    output logic      o_lt,
    output logic      o_ltu
);

    xlen_t                  s_reg_data_1;
    xlen_t                  s_reg_data_2;
    xlen_t                  s_reg_imm;
    xlen_t                  s_src_a;
    xlen_t                  s_src_b;
    xlen_t                  s_alu_result;
    logic [`RV_SHAMT_W-1:0] s_shamt;
    logic                   s_eq;
    logic                   s_lt;
    logic                   s_ltu;

    // Operand registers.
    always_ff @(posedge clk) begin
        if (i_operand_en) begin
            s_reg_data_1 <= i_rs1_data;
            s_reg_data_2 <= i_rs2_data;
            s_reg_imm    <= i_imm;
        end
    end

    //--------------------------------------------------------------------------
    // Operand selects and ALU.
    //--------------------------------------------------------------------------
    always_comb begin
        case (i_op_a_sel)
            A_PC:    s_src_a = i_pc;
            A_ZERO:  s_src_a = '0;
            default: s_src_a = s_reg_data_1;
        endcase
    end

    assign s_src_b = (i_op_b_sel == B_IMM) ? s_reg_imm : s_reg_data_2;
    assign s_shamt = s_src_b[`RV_SHAMT_W-1:0];

    // Compare flags, used by SLT/SLTU and by branch resolution.
    assign s_eq  = (s_src_a == s_src_b);
    assign s_lt  = ($signed(s_src_a) < $signed(s_src_b));
    assign s_ltu = (s_src_a < s_src_b);

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  s_alu_result = s_src_a - s_src_b;
            ALU_SLL:  s_alu_result = s_src_a << s_shamt;
            ALU_SLT:  s_alu_result = {{(`RV_XLEN-1){1'b0}}, s_lt};
            ALU_SLTU: s_alu_result = {{(`RV_XLEN-1){1'b0}}, s_ltu};
            ALU_XOR:  s_alu_result = s_src_a ^ s_src_b;
            ALU_SRL:  s_alu_result = s_src_a >> s_shamt;
            ALU_SRA:  s_alu_result = $signed(s_src_a) >>> s_shamt;
            ALU_OR:   s_alu_result = s_src_a | s_src_b;
            ALU_AND:  s_alu_result = s_src_a & s_src_b;
            default:  s_alu_result = s_src_a + s_src_b;
        endcase
    end

    // Result register.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_result <= '0;
            o_eq     <= 1'b0;
            o_lt     <= 1'b0;
            o_ltu    <= 1'b0;
        end else if (i_alu_en) begin
            o_result <= s_alu_result;
            o_eq     <= s_eq;
            o_lt     <= s_lt;
            o_ltu    <= s_ltu;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_retire.sv */
// Branch resolution, PC register, next PC and link, registered writeback report.
`default_nettype none

`include "rv_core_params.svh"

module rv_retire
    import rv_core_pkg::*;
(
    input  logic         clk,
    input  logic         i_reset,
    input  logic         i_retire,
    input  branch_cond_t i_branch_cond,
    input  logic         i_writes_rd,
    input  logic         i_illegal,
    input  reg_addr_t    i_rd,
    input  xlen_t        i_result,
    input  xlen_t        i_imm,
    input  logic         i_eq,
    input  logic         i_lt,
    input  logic         i_ltu,
    output xlen_t        o_pc,
    output logic         o_wb_valid,
    output logic         o_wb_we,
    output reg_addr_t    o_wb_rd,
    output xlen_t        o_wb_data,
    output logic         o_illegal
);

    logic  s_taken;
    xlen_t s_link;
    xlen_t s_next_pc;

    always_comb begin
        case (i_branch_cond)
            BR_EQ:   s_taken = i_eq;
            BR_NE:   s_taken = !i_eq;
            BR_LT:   s_taken = i_lt;
            BR_GE:   s_taken = !i_lt;
            BR_LTU:  s_taken = i_ltu;
            BR_GEU:  s_taken = !i_ltu;
            BR_JUMP: s_taken = 1'b1;
            default: s_taken = 1'b0;
        endcase
    end

    assign s_link    = o_pc + xlen_t'(`RV_INSTR_BYTES);
    assign s_next_pc = s_taken ? (o_pc + i_imm) : s_link;

    // Report lasts one cycle. The register file commits on the following edge.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc       <= `RV_RESET_PC;
            o_wb_valid <= 1'b0;
            o_wb_we    <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_wb_valid <= i_retire;
            o_wb_we    <= i_retire && i_writes_rd;
            o_illegal  <= i_retire && i_illegal;
            if (i_retire) begin
                o_pc <= s_next_pc;
            end
        end
    end

    // Report payload.
    always_ff @(posedge clk) begin
        if (i_retire) begin
            o_wb_rd   <= i_rd;
            o_wb_data <= (i_branch_cond == BR_JUMP) ? s_link : i_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
// Core top level with decode, register file, execute and retire.
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_instr_valid,
    input  instr_t    i_instr,
    output logic      o_ready,
    output logic      o_wb_valid,
    output logic      o_wb_we,
    output reg_addr_t o_wb_rd,
    output xlen_t     o_wb_data,
    output logic      o_illegal,
    output xlen_t     o_pc
);

    //--------------------------------------------------------------------------
    // Internal nets.
    //--------------------------------------------------------------------------
    reg_addr_t    s_rs1;
    reg_addr_t    s_rs2;
    reg_addr_t    s_rd;
    xlen_t        s_imm;
    alu_op_t      s_alu_op;
    op_a_sel_t    s_op_a_sel;
    op_b_sel_t    s_op_b_sel;
    branch_cond_t s_branch_cond;
    logic         s_writes_rd;
    logic         s_dec_illegal;
    logic         s_operand_en;
    logic         s_alu_en;
    logic         s_retire;
    xlen_t        s_rs1_data;
    xlen_t        s_rs2_data;
    xlen_t        s_result;
    logic         s_eq;
    logic         s_lt;
    logic         s_ltu;

    rv_decode decode_i (
        .clk(clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_ready(o_ready), .o_rs1(s_rs1), .o_rs2(s_rs2), .o_rd(s_rd), .o_imm(s_imm),
        .o_alu_op(s_alu_op), .o_op_a_sel(s_op_a_sel), .o_op_b_sel(s_op_b_sel),
        .o_branch_cond(s_branch_cond), .o_writes_rd(s_writes_rd), .o_illegal(s_dec_illegal),
        .o_operand_en(s_operand_en), .o_alu_en(s_alu_en), .o_retire(s_retire)
    );

    // Written from the registered writeback report.
    rv_regfile regfile_i (
        .clk(clk), .i_reset(i_reset), .i_rs1(s_rs1), .i_rs2(s_rs2), .i_rd(o_wb_rd),
        .i_we(o_wb_we), .i_wdata(o_wb_data), .o_rs1_data(s_rs1_data), .o_rs2_data(s_rs2_data)
    );

    rv_execute execute_i (
        .clk(clk), .i_reset(i_reset), .i_operand_en(s_operand_en), .i_alu_en(s_alu_en),
        .i_rs1_data(s_rs1_data), .i_rs2_data(s_rs2_data), .i_imm(s_imm), .i_pc(o_pc),
        .i_alu_op(s_alu_op), .i_op_a_sel(s_op_a_sel), .i_op_b_sel(s_op_b_sel),
        .o_result(s_result), .o_eq(s_eq), .o_lt(s_lt), .o_ltu(s_ltu)
    );

    rv_retire retire_i (
        .clk(clk), .i_reset(i_reset), .i_retire(s_retire), .i_branch_cond(s_branch_cond),
        .i_writes_rd(s_writes_rd), .i_illegal(s_dec_illegal), .i_rd(s_rd), .i_result(s_result),
        .i_imm(s_imm), .i_eq(s_eq), .i_lt(s_lt), .i_ltu(s_ltu), .o_pc(o_pc),
        .o_wb_valid(o_wb_valid), .o_wb_we(o_wb_we), .o_wb_rd(o_wb_rd),
        .o_wb_data(o_wb_data), .o_illegal(o_illegal)
    );

endmodule

`default_nettype wire

/* verif/rv_core_checker.sv */
// Concurrent assertions on the instruction handshake and the writeback report.
`default_nettype none

module rv_core_checker
    import rv_core_pkg::*;
(
    input logic      clk,
    input logic      i_reset,
    input logic      i_instr_valid,
    input logic      i_ready,
    input logic      i_wb_valid,
    input logic      i_wb_we,
    input reg_addr_t i_wb_rd,
    input logic      i_illegal
);

    // One report per instruction, never two in a row.
    wb_single_cycle: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_valid |=> !i_wb_valid)
        else $error("writeback valid stayed high for two cycles");

    // Report is visible in the cycle after the third edge past acceptance.
    accept_latency: assert property (@(posedge clk) disable iff (i_reset)
        (i_instr_valid && i_ready) |=> ##3 i_wb_valid)
        else $error("accepted instruction did not retire three edges later");

    illegal_no_write: assert property (@(posedge clk) disable iff (i_reset)
        i_illegal |-> (i_wb_valid && !i_wb_we))
        else $error("illegal flag without a report or with a register write");

    no_write_x0: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_we |-> (i_wb_rd != '0))
        else $error("register write reported for x0");

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
// Testbench for the RV64 core with a seeded random instruction stream and a reference model.
`default_nettype none

`include "rv_core_params.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int READY_TIMEOUT = 20;
    localparam int WB_TIMEOUT    = 20;

    logic      clk;
    logic      i_reset;
    logic      i_instr_valid;
    instr_t    i_instr;
    logic      o_ready;
    logic      o_wb_valid;
    logic      o_wb_we;
    reg_addr_t o_wb_rd;
    xlen_t     o_wb_data;
    logic      o_illegal;
    xlen_t     o_pc;

    xlen_t model_regs [`RV_NUM_REGS];
    xlen_t model_pc;
    int    seed = 32'hb9c83719;
    int    errors;
    int    test_count;
    int    instr_count;
    logic  timed_out;

    rv_core dut_i (
        .clk(clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_ready(o_ready), .o_wb_valid(o_wb_valid), .o_wb_we(o_wb_we), .o_wb_rd(o_wb_rd),
        .o_wb_data(o_wb_data), .o_illegal(o_illegal), .o_pc(o_pc)
    );

    bind rv_core rv_core_checker checker_i (
        .clk(clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_ready(o_ready),
        .i_wb_valid(o_wb_valid), .i_wb_we(o_wb_we), .i_wb_rd(o_wb_rd), .i_illegal(o_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    //--------------------------------------------------------------------------
    // Reference model.
    //--------------------------------------------------------------------------
    function automatic xlen_t compute_alu(input logic [2:0] f3, input logic alt,
                                          input xlen_t a, input xlen_t b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011:  return (a < b) ? 64'd1 : 64'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic predict(input instr_t instr, output logic we, output reg_addr_t rd,
                           output xlen_t data, output logic illegal, output xlen_t next_pc);
        logic [2:0] f3;
        xlen_t      rs1v;
        xlen_t      rs2v;
        xlen_t      imm_i;
        xlen_t      imm_u;
        xlen_t      imm_b;
        xlen_t      imm_j;
        logic       taken;
        f3      = instr[14:12];
        rd      = instr[11:7];
        rs1v    = model_regs[instr[19:15]];
        rs2v    = model_regs[instr[24:20]];
        imm_i   = {{52{instr[31]}}, instr[31:20]};
        imm_u   = {{32{instr[31]}}, instr[31:12], 12'h000};
        imm_b   = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        we      = 1'b1;
        data    = '0;
        illegal = 1'b0;
        taken   = 1'b0;
        next_pc = model_pc + 64'd4;
        case (instr[6:0])
            OPC_OP:     data = compute_alu(f3, instr[30] && (f3 == 3'b000 || f3 == 3'b101),
                                           rs1v, rs2v);
            OPC_OP_IMM: data = compute_alu(f3, instr[30] && (f3 == 3'b101), rs1v, imm_i);
            OPC_LUI:    data = imm_u;
            OPC_AUIPC:  data = model_pc + imm_u;
            OPC_BRANCH: begin
                we = 1'b0;
                case (f3)
                    3'b000:  taken = (rs1v == rs2v);
                    3'b001:  taken = (rs1v != rs2v);
                    3'b100:  taken = ($signed(rs1v) < $signed(rs2v));
                    3'b101:  taken = ($signed(rs1v) >= $signed(rs2v));
                    3'b110:  taken = (rs1v < rs2v);
                    3'b111:  taken = (rs1v >= rs2v);
                    default: illegal = 1'b1;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OPC_JAL: begin
                data    = model_pc + 64'd4;
                next_pc = model_pc + imm_j;
            end
            default: begin
                we      = 1'b0;
                illegal = 1'b1;
            end
        endcase
        if (rd == '0) begin
            we = 1'b0;
        end
        if (we) begin
            model_regs[rd] = data;
        end
        model_pc = next_pc;
    endtask

    //--------------------------------------------------------------------------
    // Stimulus.
    //--------------------------------------------------------------------------
    // Kinds 0 to 5 are OP, OP-IMM, LUI, AUIPC, branch and JAL. Anything else is illegal.
    task automatic random_instr(input int kind, output instr_t instr);
        int pick;
        instr = $random(seed);
        pick  = $unsigned($random(seed)) % 7;
        case (kind)
            0: begin
                instr[6:0] = OPC_OP;
                if (instr[14:12] == 3'b000 || instr[14:12] == 3'b101) begin
                    instr[31:25] = {1'b0, instr[30], 5'b0};
                end else begin
                    instr[31:25] = 7'h00;
                end
            end
            1: begin
                instr[6:0] = OPC_OP_IMM;
                // Shift immediates are a funct6 above a six-bit amount.
                if (instr[14:12] == 3'b001) begin
                    instr[31:26] = 6'b0;
                end
                if (instr[14:12] == 3'b101) begin
                    instr[31:26] = {1'b0, instr[30], 4'b0};
                end
            end
            2: instr[6:0] = OPC_LUI;
            3: instr[6:0] = OPC_AUIPC;
            4: begin
                instr[6:0] = OPC_BRANCH;
                // Same source now and then, so equal operands show up.
                if (pick < 2) begin
                    instr[24:20] = instr[19:15];
                end
            end
            5: instr[6:0] = OPC_JAL;
            default: begin
                case (pick)
                    0:       instr[6:0] = 7'b0000011;
                    1:       instr[6:0] = 7'b0100011;
                    2:       instr[6:0] = 7'b1100111;
                    3:       instr[6:0] = 7'b1110011;
                    4:       instr[6:0] = 7'b0011011;
                    5:       instr[6:0] = 7'b0111011;
                    default: instr[6:0] = 7'b0001111;
                endcase
            end
        endcase
    endtask

    // Issues one instruction, optionally strobing junk while the core is busy.
    task automatic issue_and_check(input instr_t instr, input logic drop);
        logic      exp_we;
        reg_addr_t exp_rd;
        xlen_t     exp_data;
        logic      exp_illegal;
        xlen_t     exp_pc;
        int        waited;
        int        edges;
        logic      seen;
        if (timed_out) begin
            return;
        end
        predict(instr, exp_we, exp_rd, exp_data, exp_illegal, exp_pc);
        waited = 0;
        while (!o_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_ready) begin
            $display("timeout: the core never became ready for instruction %h", instr);
            errors++;
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        i_instr_valid <= 1'b1;
        i_instr       <= instr;
        // Acceptance edge.
        @(posedge clk);
        i_instr_valid <= drop;
        i_instr       <= $random(seed);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < WB_TIMEOUT) begin
            @(negedge clk);
            if (o_wb_valid) begin
                seen = 1'b1;
            end else begin
                assert (!o_ready) else report_mismatch("o_ready", o_ready, 0);
                @(posedge clk);
                edges++;
                i_instr_valid <= drop && (edges < 3);
                i_instr       <= $random(seed);
            end
        end
        if (!seen) begin
            $display("timeout: no writeback report for instruction %h", instr);
            errors++;
            timed_out = 1'b1;
            return;
        end
        instr_count++;
        assert (edges == 3) else report_mismatch("wb latency", edges, 3);
        assert (o_ready) else report_mismatch("o_ready", o_ready, 1);
        assert (o_wb_we == exp_we) else report_mismatch("o_wb_we", o_wb_we, exp_we);
        assert (o_illegal == exp_illegal)
            else report_mismatch("o_illegal", o_illegal, exp_illegal);
        assert (o_pc == exp_pc) else report_mismatch("o_pc", o_pc, exp_pc);
        if (exp_we) begin
            assert (o_wb_rd == exp_rd) else report_mismatch("o_wb_rd", o_wb_rd, exp_rd);
            assert (o_wb_data == exp_data)
                else report_mismatch("o_wb_data", o_wb_data, exp_data);
        end
        // A dropped strobe must not turn into a second report.
        @(posedge clk);
        @(negedge clk);
        assert (!o_wb_valid) else report_mismatch("o_wb_valid", o_wb_valid, 0);
        assert (o_ready) else report_mismatch("o_ready", o_ready, 1);
    endtask

    task automatic finish_test(input string name, input int start_errors, input int count);
        $display("test %s: %0d instructions, %0d errors", name, count, errors - start_errors);
        test_count++;
    endtask

    task automatic run_random(input string name, input int count, input int first_kind,
                              input int last_kind, input logic drop);
        int     start_errors;
        int     kind;
        instr_t instr;
        start_errors = errors;
        for (int n = 0; n < count; n++) begin
            kind = first_kind + $unsigned($random(seed)) % (last_kind - first_kind + 1);
            random_instr(kind, instr);
            issue_and_check(instr, drop);
        end
        finish_test(name, start_errors, count);
    endtask

    //--------------------------------------------------------------------------
    // Test sequence.
    //--------------------------------------------------------------------------
    initial begin
        int     start_errors;
        instr_t instr;
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        errors        = 0;
        test_count    = 0;
        instr_count   = 0;
        timed_out     = 1'b0;
        model_pc      = `RV_RESET_PC;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);

        start_errors = errors;
        assert (o_ready) else report_mismatch("o_ready", o_ready, 1);
        assert (!o_wb_valid) else report_mismatch("o_wb_valid", o_wb_valid, 0);
        assert (!o_wb_we) else report_mismatch("o_wb_we", o_wb_we, 0);
        assert (!o_illegal) else report_mismatch("o_illegal", o_illegal, 0);
        assert (o_pc == `RV_RESET_PC) else report_mismatch("o_pc", o_pc, `RV_RESET_PC);
        finish_test("reset", start_errors, 0);

        run_random("alu", 200, 0, 3, 1'b0);
        run_random("control_flow", 120, 4, 5, 1'b0);
        run_random("dropped_strobes", 60, 0, 6, 1'b1);
        run_random("illegal", 40, 6, 6, 1'b0);

        // x0 writes vanish, later reads of x0 give zero.
        start_errors = errors;
        issue_and_check({12'h7ff, 5'd0, 3'b000, 5'd0, OPC_OP_IMM}, 1'b0);
        issue_and_check({20'hfffff, 5'd0, OPC_LUI}, 1'b0);
        issue_and_check({12'h05a, 5'd0, 3'b000, 5'd7, OPC_OP_IMM}, 1'b0);
        issue_and_check({7'h00, 5'd7, 5'd0, 3'b000, 5'd8, OPC_OP}, 1'b0);
        for (int n = 0; n < 16; n++) begin
            random_instr(n % 6, instr);
            instr[11:7] = 5'd0;
            issue_and_check(instr, 1'b0);
        end
        issue_and_check({7'h00, 5'd0, 5'd0, 3'b110, 5'd9, OPC_OP}, 1'b0);
        finish_test("x0", start_errors, 21);

        run_random("mixed", 300, 0, 6, 1'b0);

        $display("summary: %0d tests, %0d instructions, %0d errors",
                 test_count, instr_count, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_retire.sv
verilog/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_core_pkg.sv
      - verilog/rv_decode.sv
      - verilog/rv_regfile.sv
      - verilog/rv_execute.sv
      - verilog/rv_retire.sv
      - verilog/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/rv_core_checker.sv
      - verif/rv_core_tb.sv
